// File: hdl/rename_pkg.sv
package rename_pkg;

    // Instructions renamed per cycle.
    localparam int RENAME_WIDTH = 2;

    // Instructions retired per cycle.
    localparam int COMMIT_WIDTH = 2;

    // Source operands of one integer instruction.
    localparam int NUMSRCS_INT = 2;

    // Architectural integer registers.
    localparam int NUM_LREG = 32;

    // Physical integer registers.
    localparam int NUM_PREG = 64;

    // Index widths follow from the register counts.
    localparam int ILR_W = $clog2(NUM_LREG);
    localparam int IPR_W = $clog2(NUM_PREG);

    // Logical register index.
    typedef logic [ILR_W-1:0] ilr_idx_t;

    // Physical register index.
    typedef logic [IPR_W-1:0] ipr_idx_t;

    // One retiring instruction as the ROB hands it back.
    // prd is the register it was given at rename.
    // prev_prd is the mapping it displaced, freed at commit.
    typedef struct packed {
        logic     has_rd;
        ilr_idx_t lrd;
        ipr_idx_t prd;
        ipr_idx_t prev_prd;
    } rename_commit_info_t;

endpackage

// File: hdl/rat_map.sv
`timescale 1ns/1ns

module rat_map import rename_pkg::*; #(
    parameter int  RENAME_WIDTH = rename_pkg::RENAME_WIDTH,
    parameter int  COMMIT_WIDTH = rename_pkg::COMMIT_WIDTH,
    parameter int  NUMSRCS      = rename_pkg::NUMSRCS_INT,
    parameter type lr_idx_t     = ilr_idx_t,
    parameter type pr_idx_t     = ipr_idx_t
) (
    input  logic                      clk,
    input  logic                      i_arst_n,

    // Destination side of rename.
    input  logic [RENAME_WIDTH-1:0]   i_alloc_req,
    input  lr_idx_t                   i_lrd_idx [RENAME_WIDTH],
    input  pr_idx_t                   i_alloc_prd_idx [RENAME_WIDTH],
    output pr_idx_t                   o_renamed_prd_idx [RENAME_WIDTH],
    output pr_idx_t                   o_prev_prd_idx [RENAME_WIDTH],

    // Source side of rename.
    input  lr_idx_t                   i_lrs_idx [RENAME_WIDTH][NUMSRCS],
    output pr_idx_t                   o_renamed_prs_idx [RENAME_WIDTH][NUMSRCS],

    // Retirement and recovery.
    input  logic                      i_squash_vld,
    input  logic [COMMIT_WIDTH-1:0]   i_commit_vld,
    input  rename_commit_info_t       i_commit_info [COMMIT_WIDTH],

    // Registers released back to the free list.
    output logic [COMMIT_WIDTH-1:0]   o_dealloc_vld,
    output pr_idx_t                   o_dealloc_prd_idx [COMMIT_WIDTH]
);

    localparam int NUM_ENTRY = 2 ** $bits(lr_idx_t);

    pr_idx_t spec_map [NUM_ENTRY];
    pr_idx_t comm_map [NUM_ENTRY];
    pr_idx_t spec_next [NUM_ENTRY];
    pr_idx_t comm_next [NUM_ENTRY];

    // Committed mapping each retiring slot should have displaced.
    pr_idx_t comm_prev [COMMIT_WIDTH];

    // Lookups against the speculative table.
    // Older slots of the same group override the table, youngest first.
    always_comb begin
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            o_renamed_prd_idx[s] = i_alloc_prd_idx[s];
            o_prev_prd_idx[s] = spec_map[i_lrd_idx[s]];
            for (int o = 0; o < s; o++) begin
                if (i_alloc_req[o] && (i_lrd_idx[o] == i_lrd_idx[s])) begin
                    o_prev_prd_idx[s] = i_alloc_prd_idx[o];
                end
            end
            for (int k = 0; k < NUMSRCS; k++) begin
                o_renamed_prs_idx[s][k] = spec_map[i_lrs_idx[s][k]];
                for (int o = 0; o < s; o++) begin
                    if (i_alloc_req[o] && (i_lrd_idx[o] == i_lrs_idx[s][k])) begin
                        o_renamed_prs_idx[s][k] = i_alloc_prd_idx[o];
                    end
                end
            end
        end
    end

    // Each retiring destination frees the register it replaced.
    always_comb begin
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            o_dealloc_vld[c] = i_commit_vld[c] & i_commit_info[c].has_rd;
            o_dealloc_prd_idx[c] = pr_idx_t'(i_commit_info[c].prev_prd);
        end
    end

    // Next state of both tables.
    always_comb begin
        comm_next = comm_map;
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            if (i_commit_vld[c] && i_commit_info[c].has_rd) begin
                comm_next[lr_idx_t'(i_commit_info[c].lrd)] = pr_idx_t'(i_commit_info[c].prd);
            end
        end

        // Squash sees the committed table with this cycle's retirements.
        if (i_squash_vld) begin
            spec_next = comm_next;
        end else begin
            spec_next = spec_map;
            for (int s = 0; s < RENAME_WIDTH; s++) begin
                if (i_alloc_req[s]) begin
                    spec_next[i_lrd_idx[s]] = i_alloc_prd_idx[s];
                end
            end
        end
    end

    // Identity mapping out of reset.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int e = 0; e < NUM_ENTRY; e++) begin
                spec_map[e] <= pr_idx_t'(e);
                comm_map[e] <= pr_idx_t'(e);
            end
        end else begin
            spec_map <= spec_next;
            comm_map <= comm_next;
        end
    end

    // Committed view seen by each retiring slot, after older slots of the group.
    always_comb begin
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            comm_prev[c] = comm_map[lr_idx_t'(i_commit_info[c].lrd)];
            for (int o = 0; o < c; o++) begin
                if (i_commit_vld[o] && i_commit_info[o].has_rd &&
                    (i_commit_info[o].lrd == i_commit_info[c].lrd)) begin
                    comm_prev[c] = pr_idx_t'(i_commit_info[o].prd);
                end
            end
        end
    end

    // The ROB must hand back the mapping rename reported, in program order.
    for (genvar c = 0; c < COMMIT_WIDTH; c++) begin : g_commit_chk
        a_prev_matches_committed : assert property (
            @(posedge clk) disable iff (!i_arst_n)
            (i_commit_vld[c] && i_commit_info[c].has_rd) |->
            (pr_idx_t'(i_commit_info[c].prev_prd) == comm_prev[c])
        ) else $error("rat_map: commit slot %0d prev_prd %0d, committed map %0d",
                      c, i_commit_info[c].prev_prd, comm_prev[c]);
    end

endmodule

// File: hdl/freelist.sv
`timescale 1ns/1ns

module freelist import rename_pkg::*; #(
    parameter int NUM_PREG     = rename_pkg::NUM_PREG,
    parameter int NUM_LREG     = rename_pkg::NUM_LREG,
    parameter int RENAME_WIDTH = rename_pkg::RENAME_WIDTH,
    parameter int COMMIT_WIDTH = rename_pkg::COMMIT_WIDTH
) (
    input  logic                    clk,
    input  logic                    i_arst_n,

    // Allocation for renamed destinations.
    output logic                    o_can_alloc,
    input  logic [RENAME_WIDTH-1:0] i_alloc_req,
    output ipr_idx_t                o_alloc_pr_idx [RENAME_WIDTH],

    // Registers returned at commit.
    input  logic [COMMIT_WIDTH-1:0] i_dealloc_req,
    input  ipr_idx_t                i_dealloc_pr_idx [COMMIT_WIDTH],

    // Recovery and retirement.
    input  logic                    i_resteer_vld,
    input  logic [COMMIT_WIDTH-1:0] i_commit_vld
);

    localparam int FL_DEPTH = NUM_PREG - NUM_LREG;
    localparam int PTR_W    = $clog2(FL_DEPTH);
    localparam int CNT_W    = $clog2(FL_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    ipr_idx_t ring [FL_DEPTH];

    ptr_t spec_head;
    ptr_t comm_head;
    ptr_t tail;
    ptr_t spec_head_next;
    ptr_t comm_head_next;
    ptr_t tail_next;
    ptr_t dealloc_ptr [COMMIT_WIDTH];

    // Free entries seen by rename and by the committed state.
    cnt_t spec_cnt;
    cnt_t comm_cnt;
    cnt_t spec_cnt_next;
    cnt_t comm_cnt_next;

    cnt_t alloc_n;
    cnt_t dealloc_n;
    cnt_t commit_n;

    // Pointer advance modulo the ring depth.
    function automatic ptr_t wrap_add(input ptr_t p, input int unsigned n);
        int unsigned sum;
        sum = p + n;
        if (sum >= FL_DEPTH) begin
            sum = sum - FL_DEPTH;
        end
        return ptr_t'(sum);
    endfunction

    assign alloc_n   = cnt_t'($countones(i_alloc_req));
    assign dealloc_n = cnt_t'($countones(i_dealloc_req));
    assign commit_n  = cnt_t'($countones(i_commit_vld));

    assign o_can_alloc = (spec_cnt >= cnt_t'(RENAME_WIDTH));

    // Requesting slots take consecutive entries from the head.
    always_comb begin
        int unsigned ofs;
        ofs = 0;
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            o_alloc_pr_idx[s] = ring[wrap_add(spec_head, ofs)];
            ofs = ofs + i_alloc_req[s];
        end
    end

    // Returned registers pack onto the tail in slot order.
    always_comb begin
        int unsigned ofs;
        ofs = 0;
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            dealloc_ptr[c] = wrap_add(tail, ofs);
            ofs = ofs + i_dealloc_req[c];
        end
    end

    always_comb begin
        tail_next      = wrap_add(tail, dealloc_n);
        comm_head_next = wrap_add(comm_head, commit_n);
        comm_cnt_next  = comm_cnt + dealloc_n - commit_n;
        // Resteer drops every speculative allocation.
        if (i_resteer_vld) begin
            spec_head_next = comm_head_next;
            spec_cnt_next  = comm_cnt_next;
        end else begin
            spec_head_next = wrap_add(spec_head, alloc_n);
            spec_cnt_next  = spec_cnt + dealloc_n - alloc_n;
        end
    end

    // Out of reset the ring holds every non-architectural register.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int e = 0; e < FL_DEPTH; e++) begin
                ring[e] <= ipr_idx_t'(NUM_LREG + e);
            end
            spec_head <= '0;
            comm_head <= '0;
            tail      <= '0;
            spec_cnt  <= cnt_t'(FL_DEPTH);
            comm_cnt  <= cnt_t'(FL_DEPTH);
        end else begin
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                if (i_dealloc_req[c]) begin
                    ring[dealloc_ptr[c]] <= i_dealloc_pr_idx[c];
                end
            end
            spec_head <= spec_head_next;
            comm_head <= comm_head_next;
            tail      <= tail_next;
            spec_cnt  <= spec_cnt_next;
            comm_cnt  <= comm_cnt_next;
        end
    end

    // Speculative head never passes the committed one.
    a_count_bounds : assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (spec_cnt <= comm_cnt) && (comm_cnt <= cnt_t'(FL_DEPTH))
    ) else $error("freelist: count out of range, spec %0d comm %0d", spec_cnt, comm_cnt);

    a_alloc_when_able : assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (|i_alloc_req) |-> o_can_alloc
    ) else $error("freelist: allocation with %0d free entries", spec_cnt);

endmodule

// File: hdl/renametable.sv
`timescale 1ns/1ns

module renametable import rename_pkg::*; #(
    parameter int RENAME_WIDTH = rename_pkg::RENAME_WIDTH,
    parameter int COMMIT_WIDTH = rename_pkg::COMMIT_WIDTH,
    parameter int NUMSRCS_INT  = rename_pkg::NUMSRCS_INT,
    parameter int NUM_LREG     = rename_pkg::NUM_LREG,
    parameter int NUM_PREG     = rename_pkg::NUM_PREG
) (
    input  logic                    clk,
    input  logic                    i_arst_n,

    output logic                    o_can_rename,

    // Integer destinations.
    input  logic [RENAME_WIDTH-1:0] i_has_rd,
    input  ilr_idx_t                i_ilrd_idx [RENAME_WIDTH],
    output ipr_idx_t                o_renamed_iprd_idx [RENAME_WIDTH],
    output ipr_idx_t                o_prev_iprd_idx [RENAME_WIDTH],

    // Integer sources.
    input  ilr_idx_t                i_ilrs_idx [RENAME_WIDTH][NUMSRCS_INT],
    output ipr_idx_t                o_renamed_iprs_idx [RENAME_WIDTH][NUMSRCS_INT],

    // From the ROB.
    input  logic                    i_squash_vld,
    input  logic [COMMIT_WIDTH-1:0] i_commit_vld,
    input  rename_commit_info_t     i_commit_info [COMMIT_WIDTH]
);

    logic [RENAME_WIDTH-1:0] alloc_req;
    ipr_idx_t                alloc_iprd_idx [RENAME_WIDTH];

    logic [COMMIT_WIDTH-1:0] dealloc_vld;
    ipr_idx_t                dealloc_iprd_idx [COMMIT_WIDTH];

    logic [COMMIT_WIDTH-1:0] commit_has_rd;
    logic [COMMIT_WIDTH-1:0] commit_cnt_mask;

    // No allocation without room, and none in a squash cycle.
    assign alloc_req = i_has_rd & {RENAME_WIDTH{o_can_rename & ~i_squash_vld}};

    always_comb begin
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            commit_has_rd[c] = i_commit_info[c].has_rd;
        end
    end

    // Only retiring destinations move the committed head.
    assign commit_cnt_mask = i_commit_vld & commit_has_rd;

    rat_map #(
        .RENAME_WIDTH ( RENAME_WIDTH ),
        .COMMIT_WIDTH ( COMMIT_WIDTH ),
        .NUMSRCS      ( NUMSRCS_INT  ),
        .lr_idx_t     ( ilr_idx_t    ),
        .pr_idx_t     ( ipr_idx_t    )
    ) u_rat_map (
        .clk               ( clk                ),
        .i_arst_n          ( i_arst_n           ),
        .i_alloc_req       ( alloc_req          ),
        .i_lrd_idx         ( i_ilrd_idx         ),
        .i_alloc_prd_idx   ( alloc_iprd_idx     ),
        .o_renamed_prd_idx ( o_renamed_iprd_idx ),
        .o_prev_prd_idx    ( o_prev_iprd_idx    ),
        .i_lrs_idx         ( i_ilrs_idx         ),
        .o_renamed_prs_idx ( o_renamed_iprs_idx ),
        .i_squash_vld      ( i_squash_vld       ),
        .i_commit_vld      ( i_commit_vld       ),
        .i_commit_info     ( i_commit_info      ),
        .o_dealloc_vld     ( dealloc_vld        ),
        .o_dealloc_prd_idx ( dealloc_iprd_idx   )
    );

    freelist #(
        .NUM_PREG     ( NUM_PREG     ),
        .NUM_LREG     ( NUM_LREG     ),
        .RENAME_WIDTH ( RENAME_WIDTH ),
        .COMMIT_WIDTH ( COMMIT_WIDTH )
    ) u_freelist (
        .clk              ( clk              ),
        .i_arst_n         ( i_arst_n         ),
        .o_can_alloc      ( o_can_rename     ),
        .i_alloc_req      ( alloc_req        ),
        .o_alloc_pr_idx   ( alloc_iprd_idx   ),
        .i_dealloc_req    ( dealloc_vld      ),
        .i_dealloc_pr_idx ( dealloc_iprd_idx ),
        .i_resteer_vld    ( i_squash_vld     ),
        .i_commit_vld     ( commit_cnt_mask  )
    );

endmodule

// File: bench/tb_renametable.sv
`timescale 1ns/1ns

module tb_renametable import rename_pkg::*; ();

    localparam int FL_DEPTH      = NUM_PREG - NUM_LREG;
    localparam int PHASE1_CYCLES = 600;
    localparam int PHASE3_CYCLES = 400;
    // Random phases plus room for reset, exhaustion, squash and drain.
    localparam int TIMEOUT_CYCLES = PHASE1_CYCLES + PHASE3_CYCLES + 500;

    localparam int MODE_RANDOM = 0;
    localparam int MODE_RENAME = 1;
    localparam int MODE_SQUASH = 2;
    localparam int MODE_DRAIN  = 3;

    logic                    clk;
    logic                    i_arst_n;
    logic                    o_can_rename;
    logic [RENAME_WIDTH-1:0] i_has_rd;
    ilr_idx_t                i_ilrd_idx [RENAME_WIDTH];
    ipr_idx_t                o_renamed_iprd_idx [RENAME_WIDTH];
    ipr_idx_t                o_prev_iprd_idx [RENAME_WIDTH];
    ilr_idx_t                i_ilrs_idx [RENAME_WIDTH][NUMSRCS_INT];
    ipr_idx_t                o_renamed_iprs_idx [RENAME_WIDTH][NUMSRCS_INT];
    logic                    i_squash_vld;
    logic [COMMIT_WIDTH-1:0] i_commit_vld;
    rename_commit_info_t     i_commit_info [COMMIT_WIDTH];

    // Reference model state.
    ipr_idx_t            spec_map [NUM_LREG];
    ipr_idx_t            comm_map [NUM_LREG];
    logic                live [NUM_PREG];
    rename_commit_info_t rob_q [$];
    int                  in_flight;
    logic [31:0]         lfsr;
    int                  cycle_cnt = 0;

    // Expectations for the cycle being driven.
    logic     exp_can_rename;
    logic     ren_act;
    ipr_idx_t exp_prev [RENAME_WIDTH];
    logic     prev_byp_vld [RENAME_WIDTH];
    int       prev_byp_slot [RENAME_WIDTH];
    ipr_idx_t exp_src [RENAME_WIDTH][NUMSRCS_INT];
    logic     src_byp_vld [RENAME_WIDTH][NUMSRCS_INT];
    int       src_byp_slot [RENAME_WIDTH][NUMSRCS_INT];

    // Effects of the driven cycle, folded into the model after the edge.
    int                      pend_commits;
    logic                    pend_squash;
    logic                    pend_ren;
    logic [RENAME_WIDTH-1:0] pend_rd;
    ilr_idx_t                pend_lrd [RENAME_WIDTH];
    ipr_idx_t                pend_prd [RENAME_WIDTH];

    renametable #(
        .RENAME_WIDTH ( RENAME_WIDTH ),
        .COMMIT_WIDTH ( COMMIT_WIDTH ),
        .NUMSRCS_INT  ( NUMSRCS_INT  ),
        .NUM_LREG     ( NUM_LREG     ),
        .NUM_PREG     ( NUM_PREG     )
    ) renametable_i (
        .clk                ( clk                ),
        .i_arst_n           ( i_arst_n           ),
        .o_can_rename       ( o_can_rename       ),
        .i_has_rd           ( i_has_rd           ),
        .i_ilrd_idx         ( i_ilrd_idx         ),
        .o_renamed_iprd_idx ( o_renamed_iprd_idx ),
        .o_prev_iprd_idx    ( o_prev_iprd_idx    ),
        .i_ilrs_idx         ( i_ilrs_idx         ),
        .o_renamed_iprs_idx ( o_renamed_iprs_idx ),
        .i_squash_vld       ( i_squash_vld       ),
        .i_commit_vld       ( i_commit_vld       ),
        .i_commit_info      ( i_commit_info      )
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic value_mismatch(input string sig, input int unsigned exp_v,
                                  input int unsigned act_v);
        $display("ERROR at %0t ns: %s expected %0d, actual %0d", $time, sig, exp_v, act_v);
        abort_run();
    endtask

    task automatic rule_violation(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    // Fibonacci LFSR, taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int unsigned v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | lfsr[0];
        end
    endtask

    // Half the picks fall in r0..r7 so that bypass hits are frequent.
    task automatic pick_lreg(output ilr_idx_t r);
        int unsigned narrow;
        int unsigned v;
        take_bits(1, narrow);
        take_bits(5, v);
        r = ilr_idx_t'(narrow[0] ? (v & 7) : v);
    endtask

    task automatic apply_pending();
        rename_commit_info_t e;
        for (int c = 0; c < pend_commits; c++) begin
            e = rob_q.pop_front();
            if (e.has_rd) begin
                comm_map[e.lrd] = e.prd;
                live[e.prev_prd] = 1'b0;
                in_flight--;
            end
        end
        if (pend_ren) begin
            for (int s = 0; s < RENAME_WIDTH; s++) begin
                e = '0;
                e.lrd = pend_lrd[s];
                if (pend_rd[s]) begin
                    e.has_rd = 1'b1;
                    e.prd = pend_prd[s];
                    e.prev_prd = spec_map[pend_lrd[s]];
                    spec_map[pend_lrd[s]] = pend_prd[s];
                    live[pend_prd[s]] = 1'b1;
                    in_flight++;
                end
                rob_q.push_back(e);
            end
        end
        // Squashed destinations go back to the free pool.
        if (pend_squash) begin
            foreach (rob_q[i]) begin
                if (rob_q[i].has_rd) begin
                    live[rob_q[i].prd] = 1'b0;
                end
            end
            rob_q.delete();
            in_flight = 0;
            spec_map = comm_map;
        end
    endtask

    task automatic step_cycle(input int mode);
        int unsigned v;
        int          n_commit;
        logic        squash;
        logic        bubble;
        @(negedge clk);
        apply_pending();
        squash = 1'b0;
        bubble = 1'b0;
        n_commit = 0;
        case (mode)
            MODE_RANDOM: begin
                take_bits(5, v);
                squash = (v == 0);
                take_bits(2, v);
                n_commit = int'(v);
                take_bits(1, v);
                bubble = v[0];
            end
            MODE_SQUASH: begin
                squash = 1'b1;
                bubble = 1'b1;
            end
            MODE_DRAIN: begin
                n_commit = COMMIT_WIDTH;
                bubble = 1'b1;
            end
            default: begin
                bubble = 1'b0;
            end
        endcase
        if (n_commit > COMMIT_WIDTH) begin
            n_commit = COMMIT_WIDTH;
        end
        if (n_commit > rob_q.size()) begin
            n_commit = rob_q.size();
        end
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            take_bits(1, v);
            i_has_rd[s] = bubble ? 1'b0 : ((mode == MODE_RENAME) ? 1'b1 : v[0]);
            pick_lreg(i_ilrd_idx[s]);
            for (int k = 0; k < NUMSRCS_INT; k++) begin
                pick_lreg(i_ilrs_idx[s][k]);
            end
        end
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            i_commit_vld[c] = (c < n_commit);
            i_commit_info[c] = (c < n_commit) ? rob_q[c] : '0;
        end
        i_squash_vld = squash;

        exp_can_rename = ((FL_DEPTH - in_flight) >= RENAME_WIDTH);
        ren_act = exp_can_rename && !squash;
        // Youngest older slot writing the same register overrides the table.
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            exp_prev[s] = spec_map[i_ilrd_idx[s]];
            prev_byp_vld[s] = 1'b0;
            prev_byp_slot[s] = 0;
            for (int k = 0; k < NUMSRCS_INT; k++) begin
                exp_src[s][k] = spec_map[i_ilrs_idx[s][k]];
                src_byp_vld[s][k] = 1'b0;
                src_byp_slot[s][k] = 0;
            end
            for (int o = 0; o < s; o++) begin
                if (i_has_rd[o] && (i_ilrd_idx[o] == i_ilrd_idx[s])) begin
                    prev_byp_vld[s] = 1'b1;
                    prev_byp_slot[s] = o;
                end
                for (int k = 0; k < NUMSRCS_INT; k++) begin
                    if (i_has_rd[o] && (i_ilrd_idx[o] == i_ilrs_idx[s][k])) begin
                        src_byp_vld[s][k] = 1'b1;
                        src_byp_slot[s][k] = o;
                    end
                end
            end
        end
        pend_commits = n_commit;
        pend_squash = squash;
        pend_ren = ren_act && !bubble;
        pend_rd = i_has_rd;
        pend_lrd = i_ilrd_idx;
        // The ROB records the destinations that rename handed out.
        #1;
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            pend_prd[s] = o_renamed_iprd_idx[s];
        end
    endtask

    a_can_rename : assert property (
        @(posedge clk) disable iff (!i_arst_n) o_can_rename == exp_can_rename
    ) else value_mismatch("o_can_rename", exp_can_rename, $sampled(o_can_rename));

    for (genvar s = 0; s < RENAME_WIDTH; s++) begin : g_slot_chk
        a_prd_free : assert property (
            @(posedge clk) disable iff (!i_arst_n)
            (ren_act && i_has_rd[s]) |-> !live[o_renamed_iprd_idx[s]]
        ) else rule_violation($sformatf("o_renamed_iprd_idx[%0d] gave p%0d, which is still live",
                                        s, $sampled(o_renamed_iprd_idx[s])));

        for (genvar o = 0; o < s; o++) begin : g_pair
            a_prd_distinct : assert property (
                @(posedge clk) disable iff (!i_arst_n)
                (ren_act && i_has_rd[s] && i_has_rd[o]) |->
                (o_renamed_iprd_idx[s] != o_renamed_iprd_idx[o])
            ) else rule_violation($sformatf("slots %0d and %0d both got p%0d",
                                            o, s, $sampled(o_renamed_iprd_idx[s])));
        end

        a_prev_table : assert property (
            @(posedge clk) disable iff (!i_arst_n)
            (ren_act && !prev_byp_vld[s]) |-> (o_prev_iprd_idx[s] == exp_prev[s])
        ) else value_mismatch($sformatf("o_prev_iprd_idx[%0d]", s), exp_prev[s],
                              $sampled(o_prev_iprd_idx[s]));

        a_prev_bypass : assert property (
            @(posedge clk) disable iff (!i_arst_n)
            (ren_act && prev_byp_vld[s]) |->
            (o_prev_iprd_idx[s] == o_renamed_iprd_idx[prev_byp_slot[s]])
        ) else value_mismatch($sformatf("o_prev_iprd_idx[%0d]", s),
                              $sampled(o_renamed_iprd_idx[prev_byp_slot[s]]),
                              $sampled(o_prev_iprd_idx[s]));

        for (genvar k = 0; k < NUMSRCS_INT; k++) begin : g_src
            a_src_table : assert property (
                @(posedge clk) disable iff (!i_arst_n)
                (ren_act && !src_byp_vld[s][k]) |-> (o_renamed_iprs_idx[s][k] == exp_src[s][k])
            ) else value_mismatch($sformatf("o_renamed_iprs_idx[%0d][%0d]", s, k),
                                  exp_src[s][k], $sampled(o_renamed_iprs_idx[s][k]));

            a_src_bypass : assert property (
                @(posedge clk) disable iff (!i_arst_n)
                (ren_act && src_byp_vld[s][k]) |->
                (o_renamed_iprs_idx[s][k] == o_renamed_iprd_idx[src_byp_slot[s][k]])
            ) else value_mismatch($sformatf("o_renamed_iprs_idx[%0d][%0d]", s, k),
                                  $sampled(o_renamed_iprd_idx[src_byp_slot[s][k]]),
                                  $sampled(o_renamed_iprs_idx[s][k]));
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            rule_violation($sformatf("timeout, run still going after %0d cycles", cycle_cnt));
        end
    end

    initial begin
        i_arst_n = 1'b0;
        i_has_rd = '0;
        i_squash_vld = 1'b0;
        i_commit_vld = '0;
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            i_ilrd_idx[s] = '0;
            for (int k = 0; k < NUMSRCS_INT; k++) begin
                i_ilrs_idx[s][k] = '0;
            end
        end
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            i_commit_info[c] = '0;
        end
        // Identity map with every register past the architectural ones free.
        for (int i = 0; i < NUM_LREG; i++) begin
            spec_map[i] = ipr_idx_t'(i);
            comm_map[i] = ipr_idx_t'(i);
        end
        for (int p = 0; p < NUM_PREG; p++) begin
            live[p] = (p < NUM_LREG);
        end
        in_flight = 0;
        lfsr = 32'h4904ae0a;
        exp_can_rename = 1'b1;
        ren_act = 1'b0;
        pend_commits = 0;
        pend_squash = 1'b0;
        pend_ren = 1'b0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;

        repeat (PHASE1_CYCLES) step_cycle(MODE_RANDOM);

        // Rename with no retirement until the free list runs dry.
        while (exp_can_rename) begin
            step_cycle(MODE_RENAME);
        end

        step_cycle(MODE_SQUASH);
        repeat (PHASE3_CYCLES) step_cycle(MODE_RANDOM);

        // Retire everything, then every free register must be handed out again.
        while (rob_q.size() > pend_commits) begin
            step_cycle(MODE_DRAIN);
        end
        step_cycle(MODE_RENAME);
        while (exp_can_rename) begin
            step_cycle(MODE_RENAME);
        end

        @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: flist.f
hdl/rename_pkg.sv
hdl/rat_map.sv
hdl/freelist.sv
hdl/renametable.sv
bench/tb_renametable.sv

// File: run.sh
#!/bin/sh
# Build the rename testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_renametable \
    -f flist.f -o sim_renametable || { echo "run.sh: Verilator build failed"; exit 1; }
out=$(./obj_dir/sim_renametable 2>&1)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && echo "run.sh: simulation passed" && exit 0 \
    || { echo "run.sh: simulation failed"; exit 1; }
